/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJDIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(OBJDIR)

/* alu/alu_nibble.sv */
`timescale 1ns/1ps

module alu_nibble (
    input  alu_pkg::nibble_t a,
    input  alu_pkg::nibble_t b,
    input  alu_pkg::alu_op_t op,
    input  logic             carry_in,
    output alu_pkg::nibble_t y,
    output logic             carry_out
);
    import alu_pkg::*;

    nibble_t    b_eff;  // b, inverted for sub
    logic [4:0] sum;    // carry in bit 4

    assign b_eff = (op == SUB) ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {4'b0, carry_in};

    always_comb begin
        carry_out = carry_in;  // logic ops pass carry through
        case (op)
            ADD, SUB: begin
                y         = sum[3:0];
                carry_out = sum[4];
            end
            AND:     y = a & b;
            OR:      y = a | b;
            XOR:     y = a ^ b;
            default: y = sum[3:0];
        endcase
    end

endmodule

/* alu/nibble_loop.sv */
`timescale 1ns/1ps

module nibble_loop (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,   // nibble 0 is done in the start cycle
    input  alu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output logic             carry,   // carry out of the top nibble
    output logic             equal,   // every result nibble was zero
    output logic             busy,
    output logic             done
);
    import cpu_pkg::*;
    import alu_pkg::*;

    word_t    a_q, b_q;      // operands, shifted down a nibble per step
    word_t    a_cur, b_cur;
    alu_op_t  op_q, op_cur;
    nib_idx_t idx;           // nibble handled in this cycle
    nibble_t  y;
    logic     c_in, c_out;
    logic     step, last;

    assign a_cur = start ? a : a_q;
    assign b_cur = start ? b : b_q;
    assign op_cur = start ? op : op_q;
    assign c_in  = start ? (op == SUB) : carry;  // +1 of two's complement on nibble 0
    assign step  = start | busy;
    assign last  = busy && (idx == nib_idx_t'(nibble_count - 1));

    alu_nibble slice_i (
        .a         (a_cur[3:0]),
        .b         (b_cur[3:0]),
        .op        (op_cur),
        .carry_in  (c_in),
        .y         (y),
        .carry_out (c_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            idx  <= '0;
        end else begin
            done <= last;  // result complete after nibble 7
            if (start) begin
                busy <= 1'b1;
                idx  <= nib_idx_t'(1);
            end else if (busy) begin
                busy <= !last;
                idx  <= idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            a_q    <= {4'b0, a_cur[31:4]};
            b_q    <= {4'b0, b_cur[31:4]};
            op_q   <= op_cur;
            carry  <= c_out;                       // chained into the next nibble
            result <= {y, result[31:4]};           // fills from the top, low first
            equal  <= (start | equal) & (y == 4'b0);
        end
    end

endmodule

/* alu/shift_loop.sv */
`timescale 1ns/1ps

module shift_loop (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  alu_pkg::shift_dir_t dir,
    input  logic                arith,   // sign fill on right shifts
    input  cpu_pkg::word_t      value,
    input  logic [4:0]          amount,
    output cpu_pkg::word_t      result,
    output logic                busy,
    output logic                done
);
    import alu_pkg::*;

    logic [4:0] cnt;      // bits still to shift
    shift_dir_t dir_q;
    logic       arith_q;

    assign done = busy && (cnt == 5'd0);  // amount + 1 cycles after start

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= amount;
        end else if (done) begin
            busy <= 1'b0;
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result  <= value;
            dir_q   <= dir;
            arith_q <= arith;
        end else if (busy && !done) begin
            if (dir_q == LEFT)
                result <= {result[30:0], 1'b0};
            else
                result <= {arith_q & result[31], result[31:1]};  // one bit per cycle
        end
    end

endmodule

/* common/alu_pkg.sv */
package alu_pkg;

    typedef logic [3:0] nibble_t;   // one alu slice
    typedef logic [2:0] nib_idx_t;  // nibble position in a word

    localparam int nibble_count = 8;  // nibbles per word

    typedef enum logic [2:0] {
        ADD,
        SUB,   // b inverted, carry in of 1 on nibble 0
        AND,
        OR,
        XOR
    } alu_op_t;

    typedef enum logic {
        LEFT,
        RIGHT
    } shift_dir_t;

endpackage

/* common/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;      // data word
    typedef logic [31:0] addr_t;      // byte address
    typedef logic [4:0]  reg_idx_t;   // x0..x31
    typedef logic [1:0]  mem_size_t;  // coded like funct3[1:0] of loads and stores

    localparam mem_size_t size_byte = 2'd0;
    localparam mem_size_t size_half = 2'd1;
    localparam mem_size_t size_word = 2'd2;

    localparam addr_t reset_pc  = 32'h00ff0004;       // first fetch after reset
    localparam int    ram_bytes = 4096;
    localparam int    ram_aw    = $clog2(ram_bytes);  // addresses fold to this width

    typedef logic [ram_aw-1:0] ram_idx_t;  // folded byte address

    // major opcodes in scope, anything else traps
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC_ALU,    // one or two passes through nibble_loop
        EXEC_SHIFT,
        MEM,
        WRITEBACK,
        TRAP         // sticky until reset
    } cpu_state_t;

    typedef struct packed {
        logic     mem_we;   // write data as a word at addr
        logic     reg_we;   // write data into reg_idx
        addr_t    addr;
        reg_idx_t reg_idx;
        word_t    data;
    } host_req_t;

endpackage

/* control/control.sv */
`timescale 1ns/1ps

module control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  cpu_pkg::host_req_t  host,
    input  cpu_pkg::reg_idx_t   peek_reg,
    output cpu_pkg::word_t      peek_reg_data,
    output logic                nl_start,
    output alu_pkg::alu_op_t    nl_op,
    output cpu_pkg::word_t      nl_a,
    output cpu_pkg::word_t      nl_b,
    input  cpu_pkg::word_t      nl_result,
    input  logic                nl_carry,
    input  logic                nl_equal,
    input  logic                nl_done,
    output logic                sh_start,
    output alu_pkg::shift_dir_t sh_dir,
    output logic                sh_arith,
    output cpu_pkg::word_t      sh_value,
    output logic [4:0]          sh_amount,
    input  cpu_pkg::word_t      sh_result,
    input  logic                sh_done,
    output cpu_pkg::addr_t      mem_addr,
    output cpu_pkg::mem_size_t  mem_size,
    output logic                mem_we,
    output cpu_pkg::word_t      mem_wdata,
    input  cpu_pkg::word_t      mem_rdata,
    output cpu_pkg::addr_t      pc,
    output logic                retire,
    output logic                trap
);
    import cpu_pkg::*;
    import alu_pkg::*;

    word_t      regs [32];
    cpu_state_t state;
    word_t      ir, ins;               // ins is the raw fetch word during decode
    word_t      rs1v, rs2v, wb_val, ld_data, wb_data, alu_out;
    addr_t      addr_q, next_pc;
    opcode_t    opc;
    logic [2:0] f3;
    reg_idx_t   rd, rs1, rs2;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t    arith_op;
    logic       issued, second;        // loop started, second pass
    logic       lt, ltu, taken, is_shift, is_mem, writes_rd, need_second;

    function automatic word_t rf_read(reg_idx_t idx);
        return (idx == '0) ? '0 : regs[idx];  // x0 reads zero
    endfunction

    assign ins   = (state == DECODE) ? mem_rdata : ir;
    assign opc   = opcode_t'(ins[6:0]);
    assign f3    = ins[14:12];
    assign rd    = ins[11:7];
    assign rs1   = ins[19:15];
    assign rs2   = ins[24:20];
    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    // compare flags from the sub pass
    assign ltu   = !nl_carry;  // no carry out means a < b unsigned
    assign lt    = (nl_a[31] != nl_b[31]) ? nl_a[31] : nl_result[31];
    assign taken = (f3[2] ? (f3[1] ? ltu : lt) : nl_equal) ^ f3[0];  // odd funct3 inverts
    assign alu_out = ((opc == OP_IMM || opc == OP_REG) && f3[2:1] == 2'b01)
                     ? {31'b0, f3[0] ? ltu : lt} : nl_result;

    assign is_shift    = (f3[1:0] == 2'b01);
    assign is_mem      = (opc == OP_LOAD || opc == OP_STORE);
    assign writes_rd   = (opc != OP_STORE && opc != OP_BRANCH);
    assign need_second = !second && (opc == OP_JAL || opc == OP_JALR
                                     || (opc == OP_BRANCH && taken));
    assign wb_data     = (opc == OP_LOAD) ? ld_data : wb_val;

    assign nl_start  = (state == EXEC_ALU) && !issued;
    assign sh_start  = (state == EXEC_SHIFT) && !issued;
    assign sh_dir    = (f3 == 3'b001) ? LEFT : RIGHT;
    assign sh_arith  = ins[30];
    assign sh_value  = rs1v;
    assign sh_amount = (opc == OP_REG) ? rs2v[4:0] : ins[24:20];
    assign mem_addr  = (state == MEM) ? addr_q : pc;
    assign mem_size  = f3[1:0];
    assign mem_we    = (state == MEM) && (opc == OP_STORE);
    assign mem_wdata = rs2v;
    assign trap      = (state == TRAP);
    assign peek_reg_data = rf_read(peek_reg);

    always_comb begin
        case (f3)
            3'b000:         arith_op = (opc == OP_REG && ins[30]) ? SUB : ADD;
            3'b010, 3'b011: arith_op = SUB;  // slt, sltu
            3'b100:         arith_op = XOR;
            3'b110:         arith_op = OR;
            3'b111:         arith_op = AND;
            default:        arith_op = ADD;
        endcase
        case (f3)
            3'b000:  ld_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
            3'b001:  ld_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
            3'b100:  ld_data = {24'b0, mem_rdata[7:0]};
            3'b101:  ld_data = {16'b0, mem_rdata[15:0]};
            default: ld_data = mem_rdata;
        endcase
    end

    // loop operands, pass 0 then pass 1 for jumps and taken branches
    always_comb begin
        nl_a  = rs1v;
        nl_b  = (opc == OP_REG) ? rs2v : imm_i;  // loads and jalr also use imm_i
        nl_op = ADD;
        case (opc)
            OP_IMM, OP_REG: nl_op = arith_op;
            OP_STORE:       nl_b = imm_s;
            OP_AUIPC: begin
                nl_a = pc;
                nl_b = imm_u;
            end
            OP_JAL: begin
                nl_a = pc;
                nl_b = second ? imm_j : 32'd4;  // link first
            end
            OP_JALR: begin
                nl_a = second ? rs1v : pc;
                nl_b = second ? imm_i : 32'd4;
            end
            OP_BRANCH: begin
                nl_a  = second ? pc : rs1v;
                nl_b  = second ? imm_b : rs2v;
                nl_op = second ? ADD : SUB;     // compare, then target
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FETCH;
            pc     <= reset_pc;
            retire <= 1'b0;
            issued <= 1'b0;
            second <= 1'b0;
        end else begin
            retire <= 1'b0;
            case (state)
                FETCH: if (run) state <= DECODE;  // word at pc arrives next cycle
                DECODE: begin
                    issued <= 1'b0;
                    second <= 1'b0;
                    case (opc)
                        OP_LUI:         state <= WRITEBACK;
                        OP_IMM, OP_REG: state <= is_shift ? EXEC_SHIFT : EXEC_ALU;
                        OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE:
                                        state <= EXEC_ALU;
                        default:        state <= TRAP;
                    endcase
                end
                EXEC_ALU: begin
                    issued <= !nl_done;
                    if (nl_done && need_second)
                        second <= 1'b1;
                    else if (nl_done)
                        state <= is_mem ? MEM : WRITEBACK;
                end
                EXEC_SHIFT: begin
                    issued <= !sh_done;
                    if (sh_done) state <= WRITEBACK;
                end
                MEM: state <= WRITEBACK;  // load data in next cycle
                WRITEBACK: begin
                    pc     <= next_pc;
                    retire <= 1'b1;       // same edge as the pc update
                    state  <= FETCH;
                end
                default: state <= TRAP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WRITEBACK && writes_rd)
            regs[rd] <= wb_data;
        else if (host.reg_we && !run)
            regs[host.reg_idx] <= host.data;
        case (state)
            DECODE: begin
                ir      <= ins;
                rs1v    <= rf_read(rs1);
                rs2v    <= rf_read(rs2);
                wb_val  <= imm_u;         // lui result
                next_pc <= pc + 32'd4;    // kept unless jump or taken branch
            end
            EXEC_ALU: begin
                if (nl_done && second)
                    next_pc <= {nl_result[31:1], nl_result[0] & (opc != OP_JALR)};
                else if (nl_done && is_mem)
                    addr_q <= nl_result;
                else if (nl_done)
                    wb_val <= alu_out;    // also link address of jal, jalr
            end
            EXEC_SHIFT: if (sh_done) wb_val <= sh_result;
            default: ;
        endcase
    end

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    input  cpu_pkg::host_req_t host,
    input  cpu_pkg::addr_t     peek_addr,
    output cpu_pkg::word_t     peek_data,
    input  cpu_pkg::reg_idx_t  peek_reg,
    output cpu_pkg::word_t     peek_reg_data,
    output cpu_pkg::addr_t     pc,
    output logic               retire,
    output logic               trap
);
    import cpu_pkg::*;
    import alu_pkg::*;

    logic       nl_start, nl_carry, nl_equal, nl_done;
    alu_op_t    nl_op;
    word_t      nl_a, nl_b, nl_result;
    logic       sh_start, sh_arith, sh_done;
    shift_dir_t sh_dir;
    word_t      sh_value, sh_result;
    logic [4:0] sh_amount;
    addr_t      mem_addr;
    mem_size_t  mem_size;
    logic       mem_we;
    word_t      mem_wdata, mem_rdata;
    host_req_t  host_ram;  // host loads only while halted

    always_comb begin
        host_ram        = host;
        host_ram.mem_we = host.mem_we & ~run;
    end

    control control_i (
        .clk, .rst_n, .run, .host, .peek_reg, .peek_reg_data,
        .nl_start, .nl_op, .nl_a, .nl_b, .nl_result, .nl_carry, .nl_equal, .nl_done,
        .sh_start, .sh_dir, .sh_arith, .sh_value, .sh_amount, .sh_result, .sh_done,
        .mem_addr, .mem_size, .mem_we, .mem_wdata, .mem_rdata,
        .pc, .retire, .trap
    );

    nibble_loop nibble_loop_i (
        .clk, .rst_n,
        .start  (nl_start),
        .op     (nl_op),
        .a      (nl_a),
        .b      (nl_b),
        .result (nl_result),
        .carry  (nl_carry),
        .equal  (nl_equal),
        .busy   (),          // control tracks the pass itself
        .done   (nl_done)
    );

    shift_loop shift_loop_i (
        .clk, .rst_n,
        .start  (sh_start),
        .dir    (sh_dir),
        .arith  (sh_arith),
        .value  (sh_value),
        .amount (sh_amount),
        .result (sh_result),
        .busy   (),
        .done   (sh_done)
    );

    ram ram_i (
        .clk, .mem_addr, .mem_size, .mem_we, .mem_wdata, .mem_rdata,
        .host      (host_ram),
        .peek_addr,
        .peek_data
    );

endmodule

/* design/ram.sv */
`timescale 1ns/1ps

module ram (
    input  logic               clk,
    input  cpu_pkg::addr_t     mem_addr,
    input  cpu_pkg::mem_size_t mem_size,
    input  logic               mem_we,
    input  cpu_pkg::word_t     mem_wdata,
    output cpu_pkg::word_t     mem_rdata,   // word at mem_addr, one cycle later
    input  cpu_pkg::host_req_t host,
    input  cpu_pkg::addr_t     peek_addr,
    output cpu_pkg::word_t     peek_data
);
    import cpu_pkg::*;

    logic [7:0] mem [ram_bytes];  // little endian bytes
    ram_idx_t   wa;
    word_t      wd;
    logic [3:0] wmask;            // bytes written this cycle

    function automatic word_t rd_word(ram_idx_t at);
        return {mem[ram_idx_t'(at + 3)], mem[ram_idx_t'(at + 2)],
                mem[ram_idx_t'(at + 1)], mem[at]};
    endfunction

    // host load has priority, the core is halted then anyway
    always_comb begin
        wa    = mem_addr[ram_aw-1:0];
        wd    = mem_wdata;
        wmask = 4'b0000;
        if (host.mem_we) begin
            wa    = host.addr[ram_aw-1:0];
            wd    = host.data;
            wmask = 4'b1111;
        end else if (mem_we) begin
            case (mem_size)
                size_byte: wmask = 4'b0001;
                size_half: wmask = 4'b0011;
                size_word: wmask = 4'b1111;
                default:   wmask = 4'b0000;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wmask[i])
                mem[ram_idx_t'(wa + i)] <= wd[8*i +: 8];
        end
        mem_rdata <= rd_word(mem_addr[ram_aw-1:0]);  // unaligned reads allowed
    end

    assign peek_data = rd_word(peek_addr[ram_aw-1:0]);

endmodule

/* files.f */
+incdir+test
common/cpu_pkg.sv
common/alu_pkg.sv
alu/alu_nibble.sv
alu/nibble_loop.sv
alu/shift_loop.sv
design/ram.sv
control/control.sv
design/cpu_top.sv
test/cpu_tb.sv

/* test/cpu_tb_cases.svh */
localparam word_t x3_val    = 32'h00000100;  // load and store base so +8 hits 0x108
localparam word_t x4_val    = 32'h00000110;
localparam word_t x5_val    = 32'hdeadbeef;  // rd of every case
localparam word_t data_word = 32'h80f17f92;  // mixed byte and half signs

task automatic add_case(word_t ins, word_t a, word_t b);
    cases.push_back('{ins, a, b});  // a into x6 and b into x7
endtask

task automatic load_cases();
    word_t r;
    add_case(alu_reg(7'h00, 3'd0), 32'h7fffffff, 32'h00000001);  // add overflow
    add_case(alu_reg(7'h20, 3'd0), 32'h00000000, 32'h00000001);  // sub borrow
    add_case(alu_reg(7'h00, 3'd7), 32'hcafebabe, 32'h0f0f00ff);
    add_case(alu_reg(7'h00, 3'd6), 32'hcafebabe, 32'h0f0f00ff);
    add_case(alu_reg(7'h00, 3'd4), 32'hcafebabe, 32'h0f0f00ff);
    add_case(alu_reg(7'h00, 3'd2), 32'h80000000, 32'h7fffffff);  // slt min vs max
    add_case(alu_reg(7'h00, 3'd2), 32'h7fffffff, 32'hffffffff);
    add_case(alu_reg(7'h00, 3'd3), 32'hffffffff, 32'h00000001);  // sltu max vs 1
    add_case(alu_reg(7'h00, 3'd3), 32'h00000001, 32'hffffffff);
    add_case(alu_reg(7'h00, 3'd3), 32'h12345678, 32'h12345678);  // equal
    add_case(alu_reg(7'h00, 3'd0), xorshift(), xorshift());
    add_case(alu_reg(7'h20, 3'd0), xorshift(), xorshift());
    add_case(alu_reg(7'h00, 3'd2), xorshift(), xorshift());
    add_case(alu_reg(7'h00, 3'd3), xorshift(), xorshift());
    add_case(alu_imm(3'd0, 12'hfff), 32'h00000000, 32'h0);        // addi -1
    add_case(alu_imm(3'd2, 12'h800), 32'hfffff7ff, 32'h0);        // slti -2048
    add_case(alu_imm(3'd3, 12'hfff), 32'hfffffffe, 32'h0);        // sltiu vs max
    add_case(alu_imm(3'd4, 12'h5a5), xorshift(), 32'h0);
    add_case(alu_imm(3'd6, 12'h80f), xorshift(), 32'h0);
    add_case(alu_imm(3'd7, 12'h7f0), xorshift(), 32'h0);
    add_case(alu_reg(7'h00, 3'd1), 32'h80000001, 32'd0);          // sll by 0
    add_case(alu_reg(7'h00, 3'd1), 32'hc0000003, 32'd2);
    add_case(alu_reg(7'h00, 3'd5), 32'h80000001, 32'd2);          // srl
    add_case(alu_reg(7'h20, 3'd5), 32'h80000001, 32'd2);          // sra
    add_case(alu_reg(7'h20, 3'd5), 32'hf0000000, 32'd0);
    add_case(alu_reg(7'h00, 3'd1), xorshift(), xorshift());
    add_case(alu_reg(7'h00, 3'd5), xorshift(), xorshift());
    add_case(alu_reg(7'h20, 3'd5), 32'h8badf00d, xorshift());
    r = xorshift();
    add_case(alu_imm(3'd1, {7'h00, r[4:0]}), xorshift(), 32'h0);
    add_case(alu_imm(3'd5, 12'h000), 32'h87654321, 32'h0);        // srli 0
    r = xorshift();
    add_case(alu_imm(3'd5, {7'h20, r[4:0]}), 32'h87654321, 32'h0);
    add_case(load_ins(3'd0, 12'd8), 32'h0, 32'h0);                // lb
    add_case(load_ins(3'd0, 12'd9), 32'h0, 32'h0);
    add_case(load_ins(3'd4, 12'd8), 32'h0, 32'h0);                // lbu
    add_case(load_ins(3'd1, 12'd8), 32'h0, 32'h0);                // lh
    add_case(load_ins(3'd1, 12'd10), 32'h0, 32'h0);
    add_case(load_ins(3'd5, 12'd10), 32'h0, 32'h0);               // lhu
    add_case(load_ins(3'd2, 12'd8), 32'h0, 32'h0);                // lw
    add_case(store_ins(3'd0, 12'd8), 32'h11223344, 32'h0);        // sb
    add_case(store_ins(3'd0, 12'd11), 32'h11223344, 32'h0);
    add_case(store_ins(3'd1, 12'd10), 32'h11223344, 32'h0);       // sh upper half
    add_case(store_ins(3'd2, 12'd8), 32'h11223344, 32'h0);        // sw
    add_case(upper_ins(20'habcde, 7'h37), 32'h0, 32'h0);          // lui
    add_case(upper_ins(20'h12345, 7'h17), 32'h0, 32'h0);          // auipc
    add_case(jal_ins(-21'sd8), 32'h0, 32'h0);
    add_case(jalr_ins(12'hff9), 32'h00ff0004, 32'h0);             // odd target
    add_case(branch_ins(3'd0, -13'sd8), 32'h5, 32'h5);            // beq taken
    add_case(branch_ins(3'd0, -13'sd8), 32'h5, 32'h6);
    add_case(branch_ins(3'd1, -13'sd8), 32'h5, 32'h6);            // bne
    add_case(branch_ins(3'd4, -13'sd8), 32'hffffffff, 32'h1);     // blt signed
    add_case(branch_ins(3'd5, -13'sd8), 32'hffffffff, 32'h1);     // bge
    add_case(branch_ins(3'd6, -13'sd8), 32'hffffffff, 32'h1);     // bltu
    add_case(branch_ins(3'd7, -13'sd8), 32'hffffffff, 32'h1);     // bgeu
    add_case(32'h00000073, 32'h0, 32'h0);                         // ecall traps and stays last
endtask

/* test/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    typedef struct packed {
        word_t ins;
        word_t a;
        word_t b;
    } tcase_t;

    logic      clk, rst_n, run, expect_trap;
    host_req_t host;
    addr_t     peek_addr, pc;
    word_t     peek_data, peek_reg_data;
    reg_idx_t  peek_reg;
    logic      retire, trap;
    tcase_t    cases[$];
    word_t     rng = 32'd8450;
    int        errors = 0;
    int        checks = 0;

    cpu_top cpu_top_i (.*);

    function automatic word_t xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // rd x5, rs1 x6, rs2 x7 unless noted
    function automatic word_t alu_reg(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd7, 5'd6, f3, 5'd5, 7'h33};
    endfunction
    function automatic word_t alu_imm(logic [2:0] f3, logic [11:0] imm);
        return {imm, 5'd6, f3, 5'd5, 7'h13};
    endfunction
    function automatic word_t load_ins(logic [2:0] f3, logic [11:0] off);
        return {off, 5'd3, f3, 5'd5, 7'h03};  // base x3
    endfunction
    function automatic word_t store_ins(logic [2:0] f3, logic [11:0] off);
        return {off[11:5], 5'd6, 5'd3, f3, off[4:0], 7'h23};
    endfunction
    function automatic word_t branch_ins(logic [2:0] f3, logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd7, 5'd6, f3, imm[4:1], imm[11], 7'h63};
    endfunction
    function automatic word_t jal_ins(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd5, 7'h6f};
    endfunction
    function automatic word_t jalr_ins(logic [11:0] imm);
        return {imm, 5'd6, 3'd0, 5'd5, 7'h67};
    endfunction
    function automatic word_t upper_ins(logic [19:0] imm, logic [6:0] op);
        return {imm, 5'd5, op};
    endfunction

    `include "cpu_tb_cases.svh"

    function automatic word_t reg_value(tcase_t c, logic [4:0] idx);
        case (idx)
            5'd3:    return x3_val;
            5'd4:    return x4_val;
            5'd5:    return x5_val;
            5'd6:    return c.a;
            5'd7:    return c.b;
            default: return '0;
        endcase
    endfunction

    function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I reference for one instruction from reset_pc
    task automatic predict(input tcase_t c, output word_t x5, output addr_t npc,
                           output word_t m, output logic tr);
        word_t ins, a, b, ii, si, bi, ji, w;
        logic [1:0] off;
        logic [2:0] f3;
        logic tk;
        ins = c.ins;
        f3  = ins[14:12];
        a   = reg_value(c, ins[19:15]);
        b   = reg_value(c, ins[24:20]);
        ii  = {{20{ins[31]}}, ins[31:20]};
        si  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bi  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        ji  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        x5  = x5_val;
        npc = reset_pc + 4;
        m   = data_word;
        tr  = 1'b0;
        case (ins[6:0])
            7'h33: x5 = alu_model(f3, ins[30], a, b);
            7'h13: x5 = alu_model(f3, ins[30] && f3 == 3'd5, a, ii);
            7'h03: begin
                off = 2'(a + ii);              // base 0x108 is word aligned
                w   = data_word >> (8 * off);
                case (f3)
                    3'd0:    x5 = {{24{w[7]}}, w[7:0]};
                    3'd1:    x5 = {{16{w[15]}}, w[15:0]};
                    3'd4:    x5 = {24'b0, w[7:0]};
                    3'd5:    x5 = {16'b0, w[15:0]};
                    default: x5 = w;
                endcase
            end
            7'h23: begin
                off = 2'(a + si);
                case (f3)
                    3'd0:    m[8*off +: 8] = b[7:0];
                    3'd1:    m[8*off +: 16] = b[15:0];
                    default: m = b;
                endcase
            end
            7'h37: x5 = {ins[31:12], 12'b0};
            7'h17: x5 = reset_pc + {ins[31:12], 12'b0};
            7'h6f: begin
                x5  = reset_pc + 4;
                npc = reset_pc + ji;
            end
            7'h67: begin
                x5  = reset_pc + 4;
                npc = (a + ii) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0:    tk = a == b;
                    3'd1:    tk = a != b;
                    3'd4:    tk = $signed(a) < $signed(b);
                    3'd5:    tk = $signed(a) >= $signed(b);
                    3'd6:    tk = a < b;
                    default: tk = a >= b;
                endcase
                if (tk) npc = reset_pc + bi;
            end
            default: begin
                tr  = 1'b1;
                npc = reset_pc;
            end
        endcase
    endtask

    task automatic check(string what, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic host_write(logic mem, addr_t addr, reg_idx_t idx, word_t data);
        @(negedge clk);
        host = '{mem, !mem, addr, idx, data};
    endtask

    task automatic run_case(tcase_t c);
        word_t x5, m;
        addr_t npc;
        logic  tr;
        int    n;
        predict(c, x5, npc, m, tr);
        @(negedge clk);
        run = 1'b0;
        host_write(1'b0, '0, 5'd3, x3_val);
        host_write(1'b0, '0, 5'd4, x4_val);
        host_write(1'b0, '0, 5'd5, x5_val);
        host_write(1'b0, '0, 5'd6, c.a);
        host_write(1'b0, '0, 5'd7, c.b);
        host_write(1'b1, reset_pc, '0, c.ins);
        host_write(1'b1, 32'h108, '0, data_word);
        @(negedge clk);
        host        = '0;
        rst_n       = 1'b0;   // back to reset_pc
        expect_trap = tr;
        @(negedge clk);
        rst_n = 1'b1;
        run   = 1'b1;
        n     = 0;
        while (!retire && !trap && n < 60) begin
            @(negedge clk);
            n++;
        end
        run = 1'b0;
        if (n >= 60) begin
            errors++;
            $display("no retire or trap within 60 cycles for instruction %h", c.ins);
        end
        check($sformatf("retire %h", c.ins), {31'b0, retire}, {31'b0, !tr});
        check($sformatf("trap %h", c.ins), {31'b0, trap}, {31'b0, tr});
        check($sformatf("pc %h", c.ins), pc, npc);
        check($sformatf("x5 %h", c.ins), peek_reg_data, x5);
        check($sformatf("mem 0x108 %h", c.ins), peek_data, m);
    endtask

    trap_legal: assert property (@(posedge clk) disable iff (!rst_n) trap |-> expect_trap)
        else begin
            errors++;
            $display("trap went high on a legal instruction at %0t ns", $time);
        end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        @(posedge clk);            // case table is filled at time 0
        repeat ((cases.size() + 1) * 60) @(posedge clk);
        $display("watchdog expired, the test did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        run         = 1'b0;
        host        = '0;
        peek_addr   = 32'h108;
        peek_reg    = 5'd5;
        expect_trap = 1'b0;
        load_cases();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin           // halted core stays put
            @(negedge clk);
            check("pc after reset", pc, reset_pc);
            check("retire while halted", {31'b0, retire}, '0);
            check("trap while halted", {31'b0, trap}, '0);
        end
        foreach (cases[i]) run_case(cases[i]);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule
